//--- src/uart_pkg.sv
`default_nettype none

package uart_pkg;

   // Line timing
   localparam int CLK_HZ        = 10_000_000;
   localparam int BAUD_RATE     = 625_000;
   localparam int BAUD_DIV      = CLK_HZ / BAUD_RATE;  // 16 clocks per bit
   localparam int HALF_BAUD_DIV = BAUD_DIV / 2;

   // 8N1 framing
   localparam int DATA_BITS  = 8;
   localparam int FRAME_BITS = DATA_BITS + 2;  // Start + data + stop

   // Register map
   localparam logic ADDR_DATA   = 1'b0;
   localparam logic ADDR_STATUS = 1'b1;

   // Status bit positions
   localparam int ST_TX_DONE  = 0;
   localparam int ST_TX_READY = 1;
   localparam int ST_RX_EN    = 2;
   localparam int ST_RX_VALID = 3;
   localparam int ST_RX_ERR   = 4;

   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;
   typedef logic [15:0] baud_cnt_t;

endpackage

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import uart_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  tx_start,
   input  wire byte_t tx_data,
   output logic       tx_pin,
   output logic       tx_idle,
   output logic       tx_done
);

   // Bit state: 0 idle, 1 start, 2..9 data, 10 stop
   localparam logic [3:0] ST_IDLE  = 4'd0;
   localparam logic [3:0] ST_START = 4'd1;
   localparam logic [3:0] ST_STOP  = 4'(FRAME_BITS);

   localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(BAUD_DIV - 1);

   logic [3:0] bit_state;
   baud_cnt_t  baud_cnt;
   logic       bit_end;
   logic [2:0] data_idx;

   assign bit_end = (bit_state != ST_IDLE) && (baud_cnt == BAUD_LAST);

   // Final cycle of the stop bit
   assign tx_done = (bit_state == ST_STOP) && (baud_cnt == BAUD_LAST);

   // Idle also in the final stop cycle so a queued byte follows directly
   assign tx_idle = (bit_state == ST_IDLE) || tx_done;

   assign data_idx = 3'(bit_state - 4'd2);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_state <= ST_IDLE;
         baud_cnt  <= '0;
      end else if (tx_start) begin
         bit_state <= ST_START;  // Straight into start bit
         baud_cnt  <= '0;
      end else if (bit_end) begin
         baud_cnt <= '0;
         if (bit_state == ST_STOP)
            bit_state <= ST_IDLE;
         else
            bit_state <= bit_state + 4'd1;
      end else if (bit_state != ST_IDLE) begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   // Line level selected from the bit state
   always_comb begin
      if (bit_state == ST_IDLE || bit_state == ST_STOP)
         tx_pin = 1'b1;
      else if (bit_state == ST_START)
         tx_pin = 1'b0;
      else
         tx_pin = tx_data[data_idx];  // LSB first
   end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import uart_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic rx_en,
   input  wire logic rx_pin,
   output logic      rx_valid,
   output logic      rx_frame_err,
   output byte_t     rx_data
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(BAUD_DIV - 1);
   localparam baud_cnt_t HALF_LAST = baud_cnt_t'(HALF_BAUD_DIV - 1);
   localparam logic [2:0] LAST_BIT = 3'(DATA_BITS - 1);

   rx_state_t  state;
   baud_cnt_t  baud_cnt;
   logic [2:0] bit_idx;
   byte_t      shift_reg;

   logic       rx_meta;
   logic       rx_sync;
   logic       rx_prev;
   logic       start_edge;

   // Two-flop synchronizer plus one flop for edge detection
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx_pin;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   // Only a falling edge starts a frame, so a held-low line is ignored
   assign start_edge = rx_prev && !rx_sync;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state        <= RX_IDLE;
         baud_cnt     <= '0;
         bit_idx      <= '0;
         rx_valid     <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_valid     <= 1'b0;
         rx_frame_err <= 1'b0;

         if (!rx_en) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
         end else begin
            case (state)
               RX_IDLE: begin
                  baud_cnt <= '0;
                  if (start_edge)
                     state <= RX_START;
               end

               RX_START: begin
                  if (baud_cnt == HALF_LAST) begin
                     baud_cnt <= '0;
                     bit_idx  <= '0;
                     // Glitch shorter than half a bit is dropped
                     state    <= rx_sync ? RX_IDLE : RX_DATA;
                  end else begin
                     baud_cnt <= baud_cnt + 1'b1;
                  end
               end

               RX_DATA: begin
                  if (baud_cnt == BAUD_LAST) begin
                     baud_cnt <= '0;
                     if (bit_idx == LAST_BIT)
                        state <= RX_STOP;
                     else
                        bit_idx <= bit_idx + 3'd1;
                  end else begin
                     baud_cnt <= baud_cnt + 1'b1;
                  end
               end

               RX_STOP: begin
                  if (baud_cnt == BAUD_LAST) begin
                     baud_cnt <= '0;
                     state    <= RX_IDLE;
                     if (rx_sync)
                        rx_valid <= 1'b1;
                     else
                        rx_frame_err <= 1'b1;  // Stop bit low
                  end else begin
                     baud_cnt <= baud_cnt + 1'b1;
                  end
               end

               default: state <= RX_IDLE;
            endcase
         end
      end
   end

   // Data path: shift in at mid-bit, LSB first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && baud_cnt == BAUD_LAST)
         shift_reg <= {rx_sync, shift_reg[7:1]};
      if (state == RX_STOP && baud_cnt == BAUD_LAST && rx_sync)
         rx_data <= shift_reg;
   end

endmodule

`default_nettype wire

//--- src/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs
   import uart_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  write_en,
   input  wire logic  addr,
   input  wire word_t write_val,
   input  wire logic  tx_idle,
   input  wire logic  tx_done,
   input  wire logic  rx_valid,
   input  wire logic  rx_frame_err,
   input  wire byte_t rx_data,
   output word_t      read_val,
   output logic       tx_start,
   output byte_t      tx_data,
   output logic       rx_en
);

   byte_t tx_queue;
   logic  queue_full;
   byte_t rx_buf;

   logic  tx_done_flag;
   logic  rx_valid_flag;
   logic  rx_err_flag;

   logic  data_wr;
   logic  status_wr;
   word_t status_word;

   assign data_wr   = write_en && (addr == ADDR_DATA);
   assign status_wr = write_en && (addr == ADDR_STATUS);

   // Launch as soon as the engine can take a byte, including its last stop cycle
   assign tx_start = queue_full && tx_idle;

   // Control state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         queue_full    <= 1'b0;
         tx_done_flag  <= 1'b0;
         rx_en         <= 1'b0;
         rx_valid_flag <= 1'b0;
         rx_err_flag   <= 1'b0;
      end else begin
         if (tx_start)
            queue_full <= 1'b0;
         if (data_wr)
            queue_full <= 1'b1;  // New byte stays queued

         if (status_wr) begin
            tx_done_flag  <= write_val[ST_TX_DONE];
            rx_en         <= write_val[ST_RX_EN];
            rx_valid_flag <= write_val[ST_RX_VALID];
            rx_err_flag   <= write_val[ST_RX_ERR];
         end

         // Engine events win over a status write
         if (tx_done)
            tx_done_flag <= 1'b1;
         if (rx_valid)
            rx_valid_flag <= 1'b1;
         if (rx_frame_err)
            rx_err_flag <= 1'b1;
      end
   end

   // Byte storage
   always_ff @(posedge clk) begin
      if (data_wr)
         tx_queue <= write_val[7:0];  // Overwrites a waiting byte
      if (tx_start)
         tx_data <= tx_queue;
      if (rx_valid)
         rx_buf <= rx_data;
   end

   always_comb begin
      status_word              = '0;
      status_word[ST_TX_DONE]  = tx_done_flag;
      status_word[ST_TX_READY] = !queue_full;
      status_word[ST_RX_EN]    = rx_en;
      status_word[ST_RX_VALID] = rx_valid_flag;
      status_word[ST_RX_ERR]   = rx_err_flag;
   end

   // Read port, registered every cycle
   always_ff @(posedge clk) begin
      if (addr == ADDR_STATUS)
         read_val <= status_word;
      else
         read_val <= {24'd0, rx_buf};
   end

endmodule

`default_nettype wire

//--- src/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top
   import uart_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  rx_pin,
   input  wire logic  write_en,
   input  wire logic  addr,
   input  wire word_t write_val,
   output logic       tx_pin,
   output word_t      read_val
);

   logic  tx_start;
   byte_t tx_data;
   logic  tx_idle;
   logic  tx_done;

   logic  rx_en;
   logic  rx_valid;
   logic  rx_frame_err;
   byte_t rx_data;

   uart_regs u_regs (
      .clk          (clk),
      .rst_n        (rst_n),
      .write_en     (write_en),
      .addr         (addr),
      .write_val    (write_val),
      .tx_idle      (tx_idle),
      .tx_done      (tx_done),
      .rx_valid     (rx_valid),
      .rx_frame_err (rx_frame_err),
      .rx_data      (rx_data),
      .read_val     (read_val),
      .tx_start     (tx_start),
      .tx_data      (tx_data),
      .rx_en        (rx_en)
   );

   uart_tx u_tx (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .tx_pin   (tx_pin),
      .tx_idle  (tx_idle),
      .tx_done  (tx_done)
   );

   uart_rx u_rx (
      .clk          (clk),
      .rst_n        (rst_n),
      .rx_en        (rx_en),
      .rx_pin       (rx_pin),
      .rx_valid     (rx_valid),
      .rx_frame_err (rx_frame_err),
      .rx_data      (rx_data)
   );

endmodule

`default_nettype wire

//--- tests/uart_assert.sv
`timescale 1ns/1ps
`default_nettype none

module uart_assert (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic tx_start,
   input wire logic tx_idle,
   input wire logic tx_pin,
   input wire logic rx_pin,
   input wire logic rx_valid,
   input wire logic rx_frame_err
);

   // Start bit reaches the line the cycle after tx_start
   start_drives_line: assert property (
      @(posedge clk) disable iff (!rst_n) tx_start |=> (!tx_pin && !tx_idle)
   ) else $error("transmitter did not begin its frame after tx_start");

   // Stop decision follows the line through the synchronizer
   valid_on_high_stop: assert property (
      @(posedge clk) disable iff (!rst_n) rx_valid |-> $past(rx_pin, 3)
   ) else $error("rx_valid raised for a frame whose stop bit was low");

   err_on_low_stop: assert property (
      @(posedge clk) disable iff (!rst_n) rx_frame_err |-> !$past(rx_pin, 3)
   ) else $error("rx_frame_err raised for a frame whose stop bit was high");

   // Line rests at the stop level between frames
   idle_line_high: assert property (
      @(posedge clk) disable iff (!rst_n) (tx_idle && !tx_start) |=> tx_pin
   ) else $error("tx_pin left the idle level without tx_start");

endmodule

bind uart_top uart_assert u_assert (
   .clk          (clk),
   .rst_n        (rst_n),
   .tx_start     (tx_start),
   .tx_idle      (tx_idle),
   .tx_pin       (tx_pin),
   .rx_pin       (rx_pin),
   .rx_valid     (rx_valid),
   .rx_frame_err (rx_frame_err)
);

`default_nettype wire

//--- tests/uart_tb_tasks.svh
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// Every task starts and ends at the drive point, DRIVE_DELAY after a rising edge
task automatic next_cycle();
   @(posedge clk);
   #DRIVE_DELAY;
endtask

task automatic write_reg(input logic a, input word_t val);
   addr      = a;
   write_val = val;
   write_en  = 1'b1;
   next_cycle();
   write_en  = 1'b0;
endtask

// read_val is registered, so it shows addr one edge later
task automatic read_reg(input logic a, output word_t val);
   addr     = a;
   write_en = 1'b0;
   next_cycle();
   val = read_val;
endtask

task automatic poll_status(input word_t mask, output word_t val);
   read_reg(ADDR_STATUS, val);
   while ((val & mask) != mask)
      read_reg(ADDR_STATUS, val);
endtask

// 8N1 frame on the testbench line, stop level selectable
task automatic drive_frame(input byte_t data, input logic stop_level);
   int i;
   for (i = 0; i < FRAME_BITS; i++) begin
      if (i == FRAME_BITS - 1)
         line_drv = stop_level;
      else
         line_drv = frame_bit(data, i);
      repeat (BAUD_DIV) next_cycle();
   end
   line_drv = 1'b1;
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
   if (actual !== expected) begin
      $display("Error: %s expected %b actual %b", name, expected, actual);
      stop_on_error("line level mismatch");
   end
endtask

task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
   if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      stop_on_error("data byte mismatch");
   end
endtask

task automatic check_status(input string name, input word_t expected, input word_t actual);
   if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      stop_on_error("status word mismatch");
   end
endtask

`endif

//--- tests/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb
   import uart_pkg::*;
();

   localparam int CLK_HALF       = 50;
   localparam int DRIVE_DELAY    = 10;
   localparam int TIMEOUT_CYCLES = 40_000;  // About 20 frames of 160 cycles, wide margin

   localparam word_t MASK_TX_DONE  = 32'h1 << ST_TX_DONE;
   localparam word_t MASK_RX_EN    = 32'h1 << ST_RX_EN;
   localparam word_t MASK_RX_VALID = 32'h1 << ST_RX_VALID;
   localparam word_t MASK_RX_ERR   = 32'h1 << ST_RX_ERR;

   logic  clk;
   logic  rst_n;
   logic  rx_pin;
   logic  write_en;
   logic  addr;
   word_t write_val;
   logic  tx_pin;
   word_t read_val;

   logic  loopback;
   logic  line_drv;
   int    seed = 57;
   int    cycle_cnt = 0;
   int    frames_sent = 0;
   int    frames_checked = 0;
   byte_t frame_q[$];  // Bytes written for sending, oldest first

   assign rx_pin = loopback ? tx_pin : line_drv;

   uart_top UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx_pin    (rx_pin),
      .write_en  (write_en),
      .addr      (addr),
      .write_val (write_val),
      .tx_pin    (tx_pin),
      .read_val  (read_val)
   );

   task automatic stop_on_error(input string reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s", reason);
   endtask

   // Line level of bit 0 (start) through 9 (stop), data LSB first
   function automatic logic frame_bit(input byte_t data, input int index);
      if (index == 0)
         return 1'b0;
      else if (index == FRAME_BITS - 1)
         return 1'b1;
      else
         return data[index - 1];
   endfunction

   function automatic word_t expected_status(input logic done, input logic ready,
                                             input logic en, input logic valid,
                                             input logic err);
      word_t w;
      w              = '0;
      w[ST_TX_DONE]  = done;
      w[ST_TX_READY] = ready;
      w[ST_RX_EN]    = en;
      w[ST_RX_VALID] = valid;
      w[ST_RX_ERR]   = err;
      return w;
   endfunction

   `include "uart_tb_tasks.svh"

   task automatic send_byte(input byte_t data);
      frame_q.push_back(data);
      frames_sent++;
      write_reg(ADDR_DATA, {24'd0, data});
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         stop_on_error($sformatf("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
   end

   // Samples tx_pin at mid-bit on falling edges, away from the drive point
   initial begin : frame_monitor
      byte_t exp_byte;
      int    i;
      forever begin
         @(negedge clk);
         if (rst_n === 1'b1 && tx_pin === 1'b0) begin
            if (frame_q.size() == 0) begin
               stop_on_error("tx_pin left idle with no byte written for sending");
            end else begin
               exp_byte = frame_q.pop_front();
               repeat (HALF_BAUD_DIV) @(negedge clk);  // Middle of start bit
               for (i = 0; i < FRAME_BITS; i++) begin
                  check_bit($sformatf("frame %0d bit %0d", frames_checked, i),
                            frame_bit(exp_byte, i), tx_pin);
                  if (i < FRAME_BITS - 1)
                     repeat (BAUD_DIV) @(negedge clk);
               end
               frames_checked++;
            end
         end
      end
   end

   initial begin : main_seq
      byte_t tx_byte;
      byte_t pair_a;
      byte_t pair_b;
      word_t rd;
      int    n;

      rst_n     = 1'b0;
      write_en  = 1'b0;
      addr      = ADDR_DATA;
      write_val = '0;
      loopback  = 1'b1;
      line_drv  = 1'b1;
      repeat (10) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      next_cycle();

      check_bit("reset tx_pin", 1'b1, tx_pin);
      read_reg(ADDR_STATUS, rd);
      check_status("reset status", expected_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), rd);

      // Frame shape, receiver still off
      send_byte(8'h4B);
      poll_status(MASK_TX_DONE, rd);
      check_status("frame shape status", expected_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), rd);
      if (frames_checked != frames_sent)
         stop_on_error("frame monitor saw no frame before tx_done");
      write_reg(ADDR_STATUS, '0);

      write_reg(ADDR_STATUS, MASK_RX_EN);
      read_reg(ADDR_STATUS, rd);
      check_status("rx enable", expected_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), rd);

      for (n = 0; n < 8; n++) begin
         tx_byte = byte_t'($random(seed));
         send_byte(tx_byte);
         poll_status(MASK_RX_VALID | MASK_TX_DONE, rd);
         check_status($sformatf("loopback %0d status", n),
                      expected_status(1'b1, 1'b1, 1'b1, 1'b1, 1'b0), rd);
         read_reg(ADDR_DATA, rd);
         check_byte($sformatf("loopback %0d data", n), tx_byte, rd[7:0]);
         write_reg(ADDR_STATUS, MASK_RX_EN);  // Clears sticky flags
         read_reg(ADDR_STATUS, rd);
         check_status($sformatf("loopback %0d cleared", n),
                      expected_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), rd);
      end

      // Second byte waits in the queue behind the first
      pair_a = byte_t'($random(seed));
      pair_b = byte_t'($random(seed));
      send_byte(pair_a);
      send_byte(pair_b);
      read_reg(ADDR_STATUS, rd);
      check_status("queue full", expected_status(1'b0, 1'b0, 1'b1, 1'b0, 1'b0), rd);
      poll_status(MASK_RX_VALID | MASK_TX_DONE, rd);
      check_status("pair first status", expected_status(1'b1, 1'b1, 1'b1, 1'b1, 1'b0), rd);
      read_reg(ADDR_DATA, rd);
      check_byte("pair first data", pair_a, rd[7:0]);
      write_reg(ADDR_STATUS, MASK_RX_EN);
      poll_status(MASK_RX_VALID | MASK_TX_DONE, rd);
      check_status("pair second status", expected_status(1'b1, 1'b1, 1'b1, 1'b1, 1'b0), rd);
      read_reg(ADDR_DATA, rd);
      check_byte("pair second data", pair_b, rd[7:0]);
      write_reg(ADDR_STATUS, MASK_RX_EN);

      // Framing error from the testbench line
      loopback = 1'b0;
      tx_byte  = byte_t'($random(seed));
      drive_frame(tx_byte, 1'b0);
      poll_status(MASK_RX_ERR, rd);
      check_status("framing error status", expected_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b1), rd);
      read_reg(ADDR_DATA, rd);
      check_byte("data after framing error", pair_b, rd[7:0]);

      // Receiver off, a good frame must be ignored
      write_reg(ADDR_STATUS, '0);
      tx_byte = byte_t'($random(seed));
      drive_frame(tx_byte, 1'b1);
      repeat (2 * BAUD_DIV) next_cycle();
      read_reg(ADDR_STATUS, rd);
      check_status("rx disabled status", expected_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), rd);
      read_reg(ADDR_DATA, rd);
      check_byte("rx disabled data", pair_b, rd[7:0]);

      // Same frame with the receiver on
      write_reg(ADDR_STATUS, MASK_RX_EN);
      drive_frame(tx_byte, 1'b1);
      poll_status(MASK_RX_VALID, rd);
      check_status("line frame status", expected_status(1'b0, 1'b1, 1'b1, 1'b1, 1'b0), rd);
      read_reg(ADDR_DATA, rd);
      check_byte("line frame data", tx_byte, rd[7:0]);

      if (frames_checked == frames_sent && frame_q.size() == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         stop_on_error("transmitted frames were left unchecked by the frame monitor");
      end
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+tests
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_top.sv
tests/uart_assert.sv
tests/uart_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := uart_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
